//--- rvm_trace.txt
# P <fetch addr hex> <instruction word hex> <stall cycles>
# W <rd decimal> <expected write data hex> in writeback order
P 00000000 123450b7 0
W 1 12345000
P 00000004 fff08113 2
W 2 12344fff
P 00000008 00500193 0
W 3 00000005
P 0000000c 0000006f 1
P 00000010 abcde037 0
W 0 abcde000
P 00000014 00300233 3
W 4 00000005
P 00000018 fffff2b7 0
W 5 fffff000
P 0000001c 00001337 1
W 6 00001000
P 00000020 006283b3 0
W 7 00000000
P 00000024 00310433 2
W 8 12345004
P 00000028 402084b3 0
P 0000002c 00348533 0
W 10 00000005

//--- list.f
+incdir+.
rvm_pkg.sv
rvm_decode.sv
rvm_regfile.sv
rvm_adder.sv
rvm_control.sv
rvm_core_top.sv
tb_clock_gen.sv
rvm_core_sva.sv
tb_rvm_core.sv

//--- tb_rvm_core.sv
// Testbench for the RV32 multi-cycle core.
// Serves program words from the trace with stalls, checks fetch order and
// spacing, and compares every writeback with the trace.

`default_nettype none

`include "rvm_params.svh"

module tb_rvm_core;

    localparam int FETCH_TIMEOUT = 20;  // Cycles allowed between fetches.
    localparam int RESET_TIMEOUT = 20;

    logic                 clk;
    logic                 resetn;
    logic [`RVM_XLEN-1:0] mem_rdata;
    logic                 mem_stall;
    rvm_pkg::mem_req_t    mem_req;
    rvm_pkg::rd_write_t   wb;

    logic [`RVM_XLEN-1:0] prog_addr[$];
    logic [`RVM_XLEN-1:0] prog_word[$];
    int                   prog_stall[$];
    int                   exp_rd[$];
    logic [`RVM_XLEN-1:0] exp_data[$];

    int                   cycle;
    int                   checks;
    int                   errors;
    int                   sva_errors;
    bit                   run_aborted;
    int                   last_fetch_cycle;
    int                   last_stalls;
    logic [`RVM_XLEN-1:0] exp_addr;

    tb_clock_gen #(.PERIOD(100), .RESET_CYCLES(8)) u_clock_gen (
        .o_clk    (clk),
        .o_resetn (resetn)
    );

    rvm_core_top dut (
        .clk         (clk),
        .resetn      (resetn),
        .o_mem       (mem_req),
        .i_mem_rdata (mem_rdata),
        .i_mem_stall (mem_stall),
        .o_wb        (wb)
    );

    // --------------------
    // Helpers
    // --------------------
    task automatic load_trace();
        int    fd;
        int    code;
        string tag;
        string line;
        logic [`RVM_XLEN-1:0] a;
        logic [`RVM_XLEN-1:0] w;
        int    n;
        fd = $fopen("rvm_trace.txt", "r");
        if (fd == 0) begin
            $display("Could not open the trace file rvm_trace.txt");
            errors++;
            run_aborted = 1'b1;
            return;
        end
        while (1) begin
            code = $fscanf(fd, "%s", tag);
            if (code != 1) break;
            if (tag == "#") begin
                code = $fgets(line, fd);            // Skip comment text.
            end else if (tag == "P") begin
                code = $fscanf(fd, "%h %h %d", a, w, n);
                prog_addr.push_back(a);
                prog_word.push_back(w);
                prog_stall.push_back(n);
            end else if (tag == "W") begin
                code = $fscanf(fd, "%d %h", n, w);
                exp_rd.push_back(n);
                exp_data.push_back(w);
            end
        end
        $fclose(fd);
    endtask

    // Program word at an address, zero where nothing is mapped.
    function automatic logic [`RVM_XLEN-1:0] read_program(input logic [`RVM_XLEN-1:0] addr);
        foreach (prog_addr[i]) begin
            if (prog_addr[i] == addr) return prog_word[i];
        end
        return '0;
    endfunction

    // Unstalled fetch-to-fetch distance for one instruction word.
    function automatic int cycles_per_instr(input logic [`RVM_XLEN-1:0] word);
        logic is_add;
        logic is_addi;
        is_add  = word[6:0] == `RVM_OPC_OP && word[14:12] == 3'd0 && word[31:25] == 7'd0;
        is_addi = word[6:0] == `RVM_OPC_OP_IMM && word[14:12] == 3'd0;
        return (is_add || is_addi) ? 6 : 5;     // Adder path costs one more.
    endfunction

    task automatic check_writeback();
        int                   rd;
        logic [`RVM_XLEN-1:0] data;
        checks++;
        assert (exp_rd.size() > 0) else begin
            errors++;
            $display("** Error [%0t] unexpected writeback x%0d = %h", $time, wb.addr, wb.wdata);
        end
        if (exp_rd.size() > 0) begin
            rd   = exp_rd.pop_front();
            data = exp_data.pop_front();
            checks++;
            assert (wb.addr == rd && wb.wdata == data) else begin
                errors++;
                $display("** Error [%0t] writeback x%0d = %h, expected x%0d = %h",
                         $time, wb.addr, wb.wdata, rd, data);
            end
        end
    endtask

    // Advance to the next falling edge and look at the writeback port.
    task automatic next_cycle();
        @(negedge clk);
        cycle++;
        if (wb.wen) check_writeback();
    endtask

    task automatic wait_for_reset();
        int waited;
        waited = 0;
        while (!resetn && waited < RESET_TIMEOUT) begin
            next_cycle();
            waited++;
        end
        if (!resetn) begin
            $display("Timed out waiting for reset to be released");
            errors++;
            run_aborted = 1'b1;
        end
    endtask

    // Wait for fetch idx, check address and spacing, then serve the word.
    task automatic serve_fetch(input int idx);
        int                   waited;
        int                   stalls;
        int                   gap;
        logic [`RVM_XLEN-1:0] word;
        waited = 0;
        while (!mem_req.c_en && waited < FETCH_TIMEOUT) begin
            next_cycle();
            waited++;
        end
        if (!mem_req.c_en) begin
            $display("Timed out waiting for fetch number %0d", idx);
            errors++;
            run_aborted = 1'b1;
            return;
        end
        checks++;
        assert (mem_req.addr == exp_addr) else begin
            errors++;
            $display("** Error [%0t] fetch address %h, expected %h", $time, mem_req.addr, exp_addr);
        end
        if (idx > 0) begin
            gap = cycles_per_instr(prog_word[idx-1]) + last_stalls;
            checks++;
            assert (cycle - last_fetch_cycle == gap) else begin
                errors++;
                $display("** Error [%0t] fetch %0d came %0d cycles after the last, expected %0d",
                         $time, idx, cycle - last_fetch_cycle, gap);
            end
        end
        last_fetch_cycle = cycle;
        exp_addr         = exp_addr + `RVM_PC_STEP;
        if (idx >= prog_word.size()) return;    // Fetch past the program end.
        word   = read_program(mem_req.addr);
        stalls = prog_stall[idx];
        if (stalls > 0) stalls += $urandom % 3;
        last_stalls = stalls;
        for (int k = 0; k < stalls; k++) begin
            mem_stall = 1'b1;
            mem_rdata = ~word;                  // Must not be latched.
            next_cycle();
        end
        mem_stall = 1'b0;
        mem_rdata = word;
        next_cycle();
        mem_rdata = '0;
    endtask

    // --------------------
    // Main sequence
    // --------------------
    initial begin
        mem_rdata        = '0;
        mem_stall        = 1'b0;
        cycle            = 0;
        checks           = 0;
        errors           = 0;
        sva_errors       = 0;
        run_aborted      = 1'b0;
        last_fetch_cycle = 0;
        last_stalls      = 0;
        exp_addr         = `RVM_RESET_PC;
        void'($urandom(44));
        load_trace();
        if (!run_aborted) wait_for_reset();
        for (int idx = 0; idx <= prog_word.size() && !run_aborted; idx++) begin
            serve_fetch(idx);
        end
        if (!run_aborted) begin
            checks++;
            assert (exp_rd.size() == 0) else begin
                errors++;
                $display("** Error [%0t] %0d expected writebacks never seen", $time, exp_rd.size());
            end
        end
        sva_errors = dut.u_core_sva.fail_count;
        errors     = errors + sva_errors;
        $display("Summary: %0d checks, %0d errors, %0d of them from bound assertions",
                 checks, errors, sva_errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- rvm_core_sva.sv
// Concurrent checks on the core's fetch port, writeback port and adder strobe.
// Bound into the core top level.

`default_nettype none

module rvm_core_sva (
    input logic               clk,
    input logic               resetn,
    input rvm_pkg::mem_req_t  i_mem,
    input logic               i_mem_stall,
    input rvm_pkg::rd_write_t i_wb,
    input rvm_pkg::add_req_t  i_add
);

    int unsigned fail_count = 0;        // Assertion failures so far.

    // --------------------
    // Reset behavior
    // --------------------
    a_quiet_in_reset: assert property (@(posedge clk)
        !resetn |-> (!i_mem.c_en && !i_wb.wen && !i_add.req))
        else begin
            $error("Fetch, write or adder strobe active during reset");
            fail_count++;
        end

    // --------------------
    // Fetch port
    // --------------------
    a_addr_held_in_stall: assert property (@(posedge clk) disable iff (!resetn)
        (i_mem.c_en && i_mem_stall) |=> (i_mem.c_en && $stable(i_mem.addr)))
        else begin
            $error("Fetch address moved during a memory stall");
            fail_count++;
        end

    a_addr_word_aligned: assert property (@(posedge clk) disable iff (!resetn)
        i_mem.c_en |-> (i_mem.addr[1:0] == 2'b00))
        else begin
            $error("Fetch address not word aligned");
            fail_count++;
        end

endmodule

bind rvm_core_top rvm_core_sva u_core_sva (
    .clk         (clk),
    .resetn      (resetn),
    .i_mem       (o_mem),
    .i_mem_stall (i_mem_stall),
    .i_wb        (o_wb),
    .i_add       (add_req)
);

`default_nettype wire

//--- tb_clock_gen.sv
// Testbench clock and reset generator.
// Free-running clock and an active-low reset held for a fixed number of cycles.

`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD       = 100,
    parameter int RESET_CYCLES = 8
) (
    output logic o_clk,
    output logic o_resetn
);

    initial begin
        o_clk = 1'b0;
        forever #(PERIOD / 2) o_clk = ~o_clk;
    end

    // Release lands on a falling edge, clear of the sampling edge.
    initial begin
        o_resetn = 1'b0;
        repeat (RESET_CYCLES) @(posedge o_clk);
        @(negedge o_clk);
        o_resetn <= 1'b1;
    end

endmodule

`default_nettype wire

//--- rvm_core_top.sv
// RV32 multi-cycle core top level.
// Ties decoder, register file, adder and control together; every register
// write is mirrored on the writeback port.

`default_nettype none

`include "rvm_params.svh"

module rvm_core_top (
    input  logic                  clk,
    input  logic                  resetn,
    output rvm_pkg::mem_req_t     o_mem,
    input  logic [`RVM_XLEN-1:0]  i_mem_rdata,
    input  logic                  i_mem_stall,
    output rvm_pkg::rd_write_t    o_wb
);

    rvm_pkg::decoded_t    dec;
    rvm_pkg::add_req_t    add_req;
    rvm_pkg::rd_write_t   rd_wr;
    logic                 fetch_accept;
    logic [`RVM_XLEN-1:0] rs1_rdata;
    logic [`RVM_XLEN-1:0] rs2_rdata;
    logic [`RVM_XLEN-1:0] add_sum;
    logic                 add_valid;

    rvm_decode u_decode (
        .clk            (clk),
        .resetn         (resetn),
        .i_fetch_accept (fetch_accept),
        .i_mem_rdata    (i_mem_rdata),
        .o_dec          (dec)
    );

    rvm_regfile u_regfile (
        .clk         (clk),
        .resetn      (resetn),
        .i_rs1_addr  (dec.rs1),
        .i_rs2_addr  (dec.rs2),
        .o_rs1_rdata (rs1_rdata),
        .o_rs2_rdata (rs2_rdata),
        .i_wr        (rd_wr)
    );

    rvm_adder u_adder (
        .clk     (clk),
        .resetn  (resetn),
        .i_add   (add_req),
        .o_sum   (add_sum),
        .o_valid (add_valid)
    );

    rvm_control u_control (
        .clk            (clk),
        .resetn         (resetn),
        .i_mem_stall    (i_mem_stall),
        .o_mem          (o_mem),
        .o_fetch_accept (fetch_accept),
        .i_dec          (dec),
        .i_rs1_rdata    (rs1_rdata),
        .i_rs2_rdata    (rs2_rdata),
        .o_add          (add_req),
        .i_add_sum      (add_sum),
        .i_add_valid    (add_valid),
        .o_rd_wr        (rd_wr)
    );

    assign o_wb = rd_wr;                    // Includes x0 writes.

endmodule

`default_nettype wire

//--- rvm_control.sv
// Main control FSM and program counter.
// Sequences fetch, decode, execute and PC increment, and steers memory,
// the adder and the register file write port.

`default_nettype none

`include "rvm_params.svh"

module rvm_control (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  i_mem_stall,
    output rvm_pkg::mem_req_t     o_mem,
    output logic                  o_fetch_accept,
    input  rvm_pkg::decoded_t     i_dec,
    input  logic [`RVM_XLEN-1:0]  i_rs1_rdata,
    input  logic [`RVM_XLEN-1:0]  i_rs2_rdata,
    output rvm_pkg::add_req_t     o_add,
    input  logic [`RVM_XLEN-1:0]  i_add_sum,
    input  logic                  i_add_valid,
    output rvm_pkg::rd_write_t    o_rd_wr
);

    rvm_pkg::ctrl_state_e state;
    rvm_pkg::ctrl_state_e next_state;
    logic [`RVM_XLEN-1:0] pc;
    logic                 issued;       // Adder request already sent.
    logic                 add_req;
    logic                 add_done;
    logic                 add_state;

    // --------------------
    // Adder steering
    // --------------------
    assign add_state = state == rvm_pkg::ST_EX_ADD  ||
                       state == rvm_pkg::ST_EX_ADDI ||
                       state == rvm_pkg::ST_INC_PC;
    assign add_req   = add_state && !issued;         // First cycle only.
    assign add_done  = issued && i_add_valid;

    always_comb begin
        o_add.req = add_req;
        o_add.lhs = '0;
        o_add.rhs = '0;
        case (state)
            rvm_pkg::ST_EX_ADD: begin
                o_add.lhs = i_rs1_rdata;
                o_add.rhs = i_rs2_rdata;
            end
            rvm_pkg::ST_EX_ADDI: begin
                o_add.lhs = i_rs1_rdata;
                o_add.rhs = i_dec.imm;
            end
            rvm_pkg::ST_INC_PC: begin
                o_add.lhs = pc;
                o_add.rhs = `RVM_PC_STEP;
            end
            default: ;
        endcase
    end

    // --------------------
    // Memory and writeback
    // --------------------
    assign o_mem.c_en     = state == rvm_pkg::ST_FETCH;
    assign o_mem.addr     = pc;                     // Held through stalls.
    assign o_fetch_accept = o_mem.c_en && !i_mem_stall;

    assign o_rd_wr.wen   = state == rvm_pkg::ST_EX_LUI ||
                           ((state == rvm_pkg::ST_EX_ADD ||
                             state == rvm_pkg::ST_EX_ADDI) && add_done);
    assign o_rd_wr.addr  = i_dec.rd;
    assign o_rd_wr.wdata = (state == rvm_pkg::ST_EX_LUI) ? i_dec.imm : i_add_sum;

    always_comb begin
        next_state = state;
        case (state)
            rvm_pkg::ST_POST_RESET: next_state = rvm_pkg::ST_FETCH;
            rvm_pkg::ST_FETCH:      if (!i_mem_stall) next_state = rvm_pkg::ST_DECODE;
            rvm_pkg::ST_DECODE: begin
                case (i_dec.instr)
                    rvm_pkg::INSTR_ADD:  next_state = rvm_pkg::ST_EX_ADD;
                    rvm_pkg::INSTR_ADDI: next_state = rvm_pkg::ST_EX_ADDI;
                    rvm_pkg::INSTR_LUI:  next_state = rvm_pkg::ST_EX_LUI;
                    default:             next_state = rvm_pkg::ST_EX_NONE;
                endcase
            end
            rvm_pkg::ST_EX_ADD,
            rvm_pkg::ST_EX_ADDI:    if (add_done) next_state = rvm_pkg::ST_INC_PC;
            rvm_pkg::ST_EX_LUI,
            rvm_pkg::ST_EX_NONE:    next_state = rvm_pkg::ST_INC_PC;
            rvm_pkg::ST_INC_PC:     if (add_done) next_state = rvm_pkg::ST_FETCH;
            default:                next_state = rvm_pkg::ST_POST_RESET;
        endcase
    end

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state  <= rvm_pkg::ST_POST_RESET;
            pc     <= `RVM_RESET_PC;
            issued <= 1'b0;
        end else begin
            state <= next_state;
            if (state == rvm_pkg::ST_INC_PC && add_done) begin
                pc <= i_add_sum;                    // PC plus step.
            end
            if (add_req) begin
                issued <= 1'b1;
            end else if (add_done) begin
                issued <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- rvm_adder.sv
// Registered adder unit.
// Sum and valid come back one cycle after each request; back-to-back
// requests are accepted.

`default_nettype none

`include "rvm_params.svh"

module rvm_adder (
    input  logic                  clk,
    input  logic                  resetn,
    input  rvm_pkg::add_req_t     i_add,
    output logic [`RVM_XLEN-1:0]  o_sum,
    output logic                  o_valid
);

    // Valid tracks the request strobe.
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_add.req;
        end
    end

    // Result register, wraps modulo 2^XLEN.
    always_ff @(posedge clk) begin
        if (i_add.req) begin
            o_sum <= i_add.lhs + i_add.rhs;
        end
    end

endmodule

`default_nettype wire

//--- rvm_regfile.sv
// General purpose register file.
// Two combinational read ports, one write port, x0 hardwired to zero.

`default_nettype none

`include "rvm_params.svh"

module rvm_regfile (
    input  logic                        clk,
    input  logic                        resetn,
    input  logic [`RVM_REG_ADDR_W-1:0]  i_rs1_addr,
    input  logic [`RVM_REG_ADDR_W-1:0]  i_rs2_addr,
    output logic [`RVM_XLEN-1:0]        o_rs1_rdata,
    output logic [`RVM_XLEN-1:0]        o_rs2_rdata,
    input  rvm_pkg::rd_write_t          i_wr
);

    logic [`RVM_XLEN-1:0] regs [`RVM_NUM_REGS];

    // --------------------
    // Write port
    // --------------------
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            for (int i = 0; i < `RVM_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wr.wen && i_wr.addr != '0) begin
            regs[i_wr.addr] <= i_wr.wdata;          // x0 writes dropped.
        end
    end

    // --------------------
    // Read ports
    // --------------------
    assign o_rs1_rdata = (i_rs1_addr == '0) ? '0 : regs[i_rs1_addr];
    assign o_rs2_rdata = (i_rs2_addr == '0) ? '0 : regs[i_rs2_addr];

endmodule

`default_nettype wire

//--- rvm_decode.sv
// Instruction decoder.
// Latches the fetched word and splits it into register fields, immediate
// and instruction kind. An all-zero word decodes as unsupported.

`default_nettype none

`include "rvm_params.svh"

module rvm_decode (
    input  logic                   clk,
    input  logic                   resetn,
    input  logic                   i_fetch_accept,   // Word valid on this edge.
    input  logic [`RVM_XLEN-1:0]   i_mem_rdata,
    output rvm_pkg::decoded_t      o_dec
);

    logic [`RVM_XLEN-1:0] instr_word;
    logic [6:0]           opcode;
    logic [2:0]           funct3;
    logic [6:0]           funct7;
    logic [`RVM_XLEN-1:0] imm_i;
    logic [`RVM_XLEN-1:0] imm_u;

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            instr_word <= '0;
        end else if (i_fetch_accept) begin
            instr_word <= i_mem_rdata;
        end
    end

    // --------------------
    // Field extraction
    // --------------------
    assign opcode = instr_word[6:0];
    assign funct3 = instr_word[14:12];
    assign funct7 = instr_word[31:25];

    assign imm_i  = {{20{instr_word[31]}}, instr_word[31:20]};  // Sign extended.
    assign imm_u  = {instr_word[31:12], 12'b0};

    always_comb begin
        o_dec.rs1   = instr_word[19:15];
        o_dec.rs2   = instr_word[24:20];
        o_dec.rd    = instr_word[11:7];
        o_dec.instr = rvm_pkg::INSTR_UNSUPPORTED;
        o_dec.imm   = '0;
        if (opcode == `RVM_OPC_OP && funct3 == 3'd0 && funct7 == 7'd0) begin
            o_dec.instr = rvm_pkg::INSTR_ADD;
        end else if (opcode == `RVM_OPC_OP_IMM && funct3 == 3'd0) begin
            o_dec.instr = rvm_pkg::INSTR_ADDI;
            o_dec.imm   = imm_i;
        end else if (opcode == `RVM_OPC_LUI) begin
            o_dec.instr = rvm_pkg::INSTR_LUI;
            o_dec.imm   = imm_u;
        end
    end

endmodule

`default_nettype wire

//--- rvm_pkg.sv
// Shared types for the RV32 multi-cycle core.
// State and instruction enums plus the structs passed between blocks.

`default_nettype none

`include "rvm_params.svh"

package rvm_pkg;

    // Decoded instruction kind.
    typedef enum logic [1:0] {
        INSTR_ADD,
        INSTR_ADDI,
        INSTR_LUI,
        INSTR_UNSUPPORTED
    } instr_e;

    // Control FSM states, one execute state per instruction.
    typedef enum logic [2:0] {
        ST_POST_RESET,
        ST_FETCH,
        ST_DECODE,
        ST_EX_ADD,
        ST_EX_ADDI,
        ST_EX_LUI,
        ST_EX_NONE,
        ST_INC_PC
    } ctrl_state_e;

    // --------------------
    // Structs
    // --------------------
    typedef struct packed {
        logic                       c_en;   // Fetch enable.
        logic [`RVM_XLEN-1:0]       addr;   // Word address.
    } mem_req_t;

    typedef struct packed {
        instr_e                     instr;
        logic [`RVM_REG_ADDR_W-1:0] rs1;
        logic [`RVM_REG_ADDR_W-1:0] rs2;
        logic [`RVM_REG_ADDR_W-1:0] rd;
        logic [`RVM_XLEN-1:0]       imm;    // Already extended.
    } decoded_t;

    typedef struct packed {
        logic                       req;    // One-cycle strobe.
        logic [`RVM_XLEN-1:0]       lhs;
        logic [`RVM_XLEN-1:0]       rhs;
    } add_req_t;

    typedef struct packed {
        logic                       wen;
        logic [`RVM_REG_ADDR_W-1:0] addr;
        logic [`RVM_XLEN-1:0]       wdata;
    } rd_write_t;

endpackage

`default_nettype wire

//--- rvm_params.svh
// Core parameters for the RV32 multi-cycle core.
// Widths, reset PC, PC step and the major opcodes that the decoder recognises.

`ifndef RVM_PARAMS_SVH
`define RVM_PARAMS_SVH

// --------------------
// Widths
// --------------------
`define RVM_XLEN        32              // Data and address width.
`define RVM_REG_ADDR_W  5               // Register index width.
`define RVM_NUM_REGS    32              // Architectural registers.

// --------------------
// Program counter
// --------------------
`define RVM_RESET_PC    32'h0000_0000   // First fetch address.
`define RVM_PC_STEP     32'd4           // One instruction word.

// Major opcodes, instruction bits [6:0].
`define RVM_OPC_OP      7'b0110011      // Register-register ALU.
`define RVM_OPC_OP_IMM  7'b0010011      // Register-immediate ALU.
`define RVM_OPC_LUI     7'b0110111      // Load upper immediate.

`endif
